//--- verilog.f
+incdir+include
design/ahb_pkg.sv
design/ahb_decoder.sv
design/ahb_ram_slave.sv
design/ahb_gpio_slave.sv
design/ahb_response_mux.sv
design/ahb_matrix.sv
tests/tb_clock_gen.sv
tests/ahb_matrix_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module ahb_matrix_tb -o ahb_matrix_sim \
    > build.log 2>&1 \
    && ./obj_dir/ahb_matrix_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failures"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "No pass line found in sim.log"; exit 1; }
exit 0

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int pass_count;
int fail_count;

// --------------------
// Compare tasks
// --------------------
task automatic check_data(input string name, input ahb_pkg::ahb_data_u actual,
                          input ahb_pkg::ahb_data_u expected);
    if (actual.word === expected.word) begin
        pass_count++;
        $display("ok    %s: %08h", name, actual.word);
    end else begin
        fail_count++;
        $display("FAIL  %0t %s: got %08h, expected %08h", $time, name, actual.word,
                 expected.word);
    end
endtask

task automatic check_resp(input string name, input logic hresp);
    if (hresp === 1'b0) begin
        pass_count++;
        $display("ok    %s: OKAY response", name);
    end else begin
        fail_count++;
        $display("FAIL  %0t %s: hresp is %b", $time, name, hresp);
    end
endtask

task automatic check_gpio(input string name, input ahb_pkg::gpio_out_t actual,
                          input ahb_pkg::gpio_out_t expected);
    if (actual === expected) begin
        pass_count++;
        $display("ok    %s: gpio_out %h", name, actual);
    end else begin
        fail_count++;
        $display("FAIL  %0t %s: gpio_out %h, expected %h", $time, name, actual, expected);
    end
endtask

`endif

//--- tests/ahb_matrix_tb.sv
`timescale 1ns/1ps

module ahb_matrix_tb;
    import ahb_pkg::*;

    localparam int          RESET_CYCLES  = 16;
    localparam int          READY_TIMEOUT = 20;
    localparam logic [1:0]  TGT_RAM       = 2'd0;
    localparam logic [1:0]  TGT_GPIO      = 2'd1;
    localparam logic [1:0]  TGT_NONE      = 2'd2;
    localparam logic [31:0] GPIO_BASE     = 32'h1f80_0000;
    localparam gpio_in_t    GPIO_IN_VALUE = {18'h2a5c3, 5'h15};

    typedef struct packed {
        logic        write;
        logic [1:0]  target;
        logic [31:0] addr;
        logic [2:0]  size;
        ahb_data_u   data;
        ahb_data_u   expected;  // Read entries only
    } entry_t;

    logic      clk;
    logic      arst_n;
    ahb_req_t  req;
    ahb_data_u hwdata;
    gpio_in_t  gpio_in;
    ahb_data_u hrdata;
    logic      hready;
    logic      hresp;
    gpio_out_t gpio_out;

    entry_t    tbl[$];
    string     tbl_name[$];
    gpio_out_t gpio_model;  // Expected LED and hex state
    logic      gpio_dirty;
    logic      timed_out;

    `include "tb_checks.svh"

    tb_clock_gen tb_clock_gen_inst (.clk(clk));

    ahb_matrix ahb_matrix_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .hwdata   (hwdata),
        .gpio_in  (gpio_in),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp),
        .gpio_out (gpio_out)
    );

    task automatic add_entry(input string name, input logic write, input logic [1:0] target,
                             input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data, input logic [31:0] expected);
        entry_t e;
        e = {write, target, addr, size, data, expected};
        tbl.push_back(e);
        tbl_name.push_back(name);
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        ahb_data_u   w [4];
        ahb_data_u   base;
        ahb_data_u   part;
        ahb_data_u   merged;
        ahb_data_u   hex;
        ahb_data_u   pipe;
        logic [31:0] ram_addr [4] = '{32'h000, 32'h004, 32'h550, 32'hffc};
        for (int i = 0; i < 4; i++) begin
            w[i].word = $urandom();
            add_entry($sformatf("ram write %03h", ram_addr[i]), 1'b1, TGT_RAM, ram_addr[i],
                      HSIZE_WORD, w[i].word, '0);
        end
        for (int i = 0; i < 4; i++)
            add_entry($sformatf("ram read %03h", ram_addr[i]), 1'b0, TGT_RAM, ram_addr[i],
                      HSIZE_WORD, '0, w[i].word);

        // Lane n of the word holds byte address n
        base.word = $urandom();
        part.word = $urandom();
        merged    = base;
        add_entry("lane base word", 1'b1, TGT_RAM, 32'h100, HSIZE_WORD, base.word, '0);
        add_entry("byte at 101", 1'b1, TGT_RAM, 32'h101, HSIZE_BYTE, part.word, '0);
        merged.lane[1] = part.lane[1];
        add_entry("half at 102", 1'b1, TGT_RAM, 32'h102, HSIZE_HALF, part.word, '0);
        merged.lane[2] = part.lane[2];
        merged.lane[3] = part.lane[3];
        add_entry("read after byte/half", 1'b0, TGT_RAM, 32'h100, HSIZE_WORD, '0, merged.word);
        add_entry("byte at 100", 1'b1, TGT_RAM, 32'h100, HSIZE_BYTE, part.word, '0);
        merged.lane[0] = part.lane[0];
        add_entry("read after byte 100", 1'b0, TGT_RAM, 32'h100, HSIZE_WORD, '0, merged.word);
        add_entry("half at 100", 1'b1, TGT_RAM, 32'h100, HSIZE_HALF, base.word, '0);
        merged.lane[0] = base.lane[0];
        merged.lane[1] = base.lane[1];
        add_entry("byte at 103", 1'b1, TGT_RAM, 32'h103, HSIZE_BYTE, base.word, '0);
        merged.lane[3] = base.lane[3];
        add_entry("read after half/byte", 1'b0, TGT_RAM, 32'h100, HSIZE_WORD, '0, merged.word);

        hex.word = $urandom();
        add_entry("gpio red write", 1'b1, TGT_GPIO, GPIO_BASE + 32'h00, HSIZE_WORD,
                  32'hffff_ffff, '0);
        add_entry("gpio green write", 1'b1, TGT_GPIO, GPIO_BASE + 32'h04, HSIZE_WORD,
                  32'h1234_5678, '0);
        add_entry("gpio hex write", 1'b1, TGT_GPIO, GPIO_BASE + 32'h08, HSIZE_WORD, hex.word, '0);
        add_entry("gpio red read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h00, HSIZE_WORD, '0,
                  32'h0003_ffff);
        add_entry("gpio green read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h04, HSIZE_WORD, '0,
                  32'h0000_0078);
        add_entry("gpio hex read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h08, HSIZE_WORD, '0, hex.word);
        add_entry("gpio switch read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h0c, HSIZE_WORD, '0,
                  32'h0002_a5c3);
        add_entry("gpio button read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h10, HSIZE_WORD, '0,
                  32'h0000_0015);

        // RAM, GPIO, RAM back to back
        pipe.word = $urandom();
        add_entry("pipe ram write", 1'b1, TGT_RAM, 32'h200, HSIZE_WORD, pipe.word, '0);
        add_entry("pipe gpio read", 1'b0, TGT_GPIO, GPIO_BASE + 32'h08, HSIZE_WORD, '0, hex.word);
        add_entry("pipe ram read", 1'b0, TGT_RAM, 32'h200, HSIZE_WORD, '0, pipe.word);

        add_entry("unmapped write", 1'b1, TGT_NONE, 32'h0400_0200, HSIZE_WORD, $urandom(), '0);
        add_entry("ram after unmapped", 1'b0, TGT_RAM, 32'h200, HSIZE_WORD, '0, pipe.word);
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual == expected) begin
            pass_count++;
            $display("ok    %s: %0d", name, actual);
        end else begin
            fail_count++;
            $display("FAIL  %0t %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    function automatic ahb_req_t make_req(input entry_t e);
        ahb_req_t r;
        r.haddr  = e.addr;
        r.hsize  = e.size;
        r.htrans = HTRANS_NONSEQ;
        r.hwrite = e.write;
        return r;
    endfunction

    // Counts the low cycles of the current data phase
    task automatic wait_ready(output logic ok, output int low_cycles);
        ok         = 1'b0;
        low_cycles = 0;
        for (int n = 0; n < READY_TIMEOUT; n++) begin
            @(negedge clk);
            if (hready === 1'b1) begin
                ok = 1'b1;
                break;
            end
            low_cycles++;
        end
    endtask

    // Sampled on the negedge before the completing edge
    task automatic check_entry(input int k, input int low_cycles);
        entry_t e;
        e = tbl[k];
        if (gpio_dirty)
            check_gpio({"gpio_out before ", tbl_name[k]}, gpio_out, gpio_model);
        gpio_dirty = 1'b0;
        check_resp(tbl_name[k], hresp);
        check_count({tbl_name[k], " wait states"}, low_cycles,
                    (e.target == TGT_RAM) ? RAM_WAIT_STATES : 0);
        if (!e.write) begin
            check_data(tbl_name[k], hrdata, e.expected);
        end else if (e.target != TGT_RAM) begin
            gpio_dirty = 1'b1;
            if (e.target == TGT_GPIO) begin
                case (e.addr[4:0])
                    GPIO_RED_OFFSET:   gpio_model.red_leds   = e.data.word[N_RED_LEDS-1:0];
                    GPIO_GREEN_OFFSET: gpio_model.green_leds = e.data.word[N_GREEN_LEDS-1:0];
                    GPIO_HEX_OFFSET:   gpio_model.hex        = e.data.word;
                    default: ;
                endcase
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int   low;
        logic ok;
        void'($urandom(7125));
        arst_n  <= 1'b0;
        req     <= '0;
        hwdata  <= '0;
        gpio_in <= GPIO_IN_VALUE;
        gpio_model = '0;
        gpio_dirty = 1'b0;
        timed_out  = 1'b0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_count("reset hready", int'(hready), 1);
        check_resp("reset hresp", hresp);
        check_gpio("reset gpio_out", gpio_out, '0);

        @(posedge clk);
        req <= make_req(tbl[0]);
        for (int i = 0; i <= tbl.size(); i++) begin
            wait_ready(ok, low);
            if (!ok) begin
                $display("Timeout, hready stayed low for %0d cycles after entry %0d",
                         READY_TIMEOUT, i - 1);
                fail_count++;
                timed_out = 1'b1;
                break;
            end
            if (i > 0)
                check_entry(i - 1, low);
            @(posedge clk);
            if (i < tbl.size())
                hwdata <= tbl[i].data;  // Data phase of the entry just accepted
            else
                hwdata <= '0;
            if (i + 1 < tbl.size())
                req <= make_req(tbl[i + 1]);
            else
                req <= '0;
        end

        if (!timed_out) begin
            @(negedge clk);
            check_gpio("final gpio_out", gpio_out, gpio_model);
        end

        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;  // 50 ns half period

endmodule

//--- design/ahb_matrix.sv
`timescale 1ns/1ps

module ahb_matrix (
    input  logic               clk,
    input  logic               arst_n,
    input  ahb_pkg::ahb_req_t  req,
    input  ahb_pkg::ahb_data_u hwdata,
    input  ahb_pkg::gpio_in_t  gpio_in,
    output ahb_pkg::ahb_data_u hrdata,
    output logic               hready,
    output logic               hresp,
    output ahb_pkg::gpio_out_t gpio_out
);
    import ahb_pkg::*;

    dev_sel_t hsel;    // Address phase
    dev_sel_t hsel_r;  // Data phase
    ahb_rsp_t ram_rsp;
    ahb_rsp_t gpio_rsp;

    // --------------------
    // Interconnect
    // --------------------
    ahb_decoder ahb_decoder_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .haddr  (req.haddr),
        .hready (hready),
        .hsel   (hsel),
        .hsel_r (hsel_r)
    );

    ahb_response_mux ahb_response_mux_inst (
        .hsel_r   (hsel_r),
        .ram_rsp  (ram_rsp),
        .gpio_rsp (gpio_rsp),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp)
    );

    // --------------------
    // Slaves
    // --------------------
    ahb_ram_slave #(
        .WAIT_STATES (RAM_WAIT_STATES)
    ) ahb_ram_slave_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .hsel   (hsel[DEV_RAM]),
        .hready (hready),
        .hwdata (hwdata),
        .rsp    (ram_rsp)
    );

    ahb_gpio_slave ahb_gpio_slave_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .hsel     (hsel[DEV_GPIO]),
        .hready   (hready),
        .hwdata   (hwdata),
        .gpio_in  (gpio_in),
        .rsp      (gpio_rsp),
        .gpio_out (gpio_out)
    );

endmodule

//--- design/ahb_response_mux.sv
`timescale 1ns/1ps

module ahb_response_mux (
    input  ahb_pkg::dev_sel_t  hsel_r,
    input  ahb_pkg::ahb_rsp_t  ram_rsp,
    input  ahb_pkg::ahb_rsp_t  gpio_rsp,
    output ahb_pkg::ahb_data_u hrdata,
    output logic               hready,
    output logic               hresp
);
    import ahb_pkg::*;

    ahb_rsp_t sel_rsp;

    // Lowest set bit wins
    always_comb begin
        if (hsel_r[DEV_RAM])
            sel_rsp = ram_rsp;
        else if (hsel_r[DEV_GPIO])
            sel_rsp = gpio_rsp;
        else
            sel_rsp = ram_rsp;  // Nothing selected
    end

    assign hrdata = sel_rsp.hrdata;
    assign hready = sel_rsp.hreadyout;
    assign hresp  = sel_rsp.hresp;

endmodule

//--- design/ahb_gpio_slave.sv
`timescale 1ns/1ps

module ahb_gpio_slave (
    input  logic               clk,
    input  logic               arst_n,
    input  ahb_pkg::ahb_req_t  req,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::ahb_data_u hwdata,
    input  ahb_pkg::gpio_in_t  gpio_in,
    output ahb_pkg::ahb_rsp_t  rsp,
    output ahb_pkg::gpio_out_t gpio_out
);
    import ahb_pkg::*;

    logic                         accept;
    logic                         active_r;
    logic                         write_r;
    logic [GPIO_OFFSET_WIDTH-1:0] offset_r;

    assign accept = hready && hsel && (req.htrans == HTRANS_NONSEQ);

    always_ff @(posedge clk) begin
        if (accept) begin
            offset_r <= req.haddr[GPIO_OFFSET_WIDTH-1:0];
            write_r  <= req.hwrite;
        end
    end

    // --------------------
    // Output registers
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_r <= 1'b0;
            gpio_out <= '0;
        end else begin
            if (active_r && write_r && hready) begin
                case (offset_r)
                    GPIO_RED_OFFSET:   gpio_out.red_leds   <= hwdata.word[N_RED_LEDS-1:0];
                    GPIO_GREEN_OFFSET: gpio_out.green_leds <= hwdata.word[N_GREEN_LEDS-1:0];
                    GPIO_HEX_OFFSET:   gpio_out.hex        <= hwdata.word[HEX_WIDTH-1:0];
                    default: ;  // Switches and buttons are read only
                endcase
            end
            if (hready)
                active_r <= accept;
        end
    end

    // Read back, zero-extended
    always_comb begin
        rsp           = '0;
        rsp.hreadyout = 1'b1;
        case (offset_r)
            GPIO_RED_OFFSET:   rsp.hrdata.word[N_RED_LEDS-1:0]   = gpio_out.red_leds;
            GPIO_GREEN_OFFSET: rsp.hrdata.word[N_GREEN_LEDS-1:0] = gpio_out.green_leds;
            GPIO_HEX_OFFSET:   rsp.hrdata.word[HEX_WIDTH-1:0]    = gpio_out.hex;
            GPIO_SW_OFFSET:    rsp.hrdata.word[N_SWITCHES-1:0]   = gpio_in.switches;
            GPIO_BTN_OFFSET:   rsp.hrdata.word[N_BUTTONS-1:0]    = gpio_in.buttons;
            default: ;
        endcase
    end

endmodule

//--- design/ahb_ram_slave.sv
`timescale 1ns/1ps

module ahb_ram_slave #(
    parameter int WAIT_STATES = ahb_pkg::RAM_WAIT_STATES
) (
    input  logic               clk,
    input  logic               arst_n,
    input  ahb_pkg::ahb_req_t  req,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::ahb_data_u hwdata,
    output ahb_pkg::ahb_rsp_t  rsp
);
    import ahb_pkg::*;

    localparam int RAM_DEPTH = 1 << RAM_ADDR_WIDTH;
    localparam int CNT_WIDTH = (WAIT_STATES > 1) ? $clog2(WAIT_STATES + 1) : 1;

    ahb_data_u mem [RAM_DEPTH];

    logic                      accept;
    logic                      complete;
    logic                      active_r;
    logic                      write_r;
    logic [RAM_ADDR_WIDTH-1:0] addr_r;
    logic [2:0]                size_r;
    logic [1:0]                offset_r;
    logic [CNT_WIDTH-1:0]      wait_cnt;
    logic [3:0]                lane_en;

    assign accept   = hready && hsel && (req.htrans == HTRANS_NONSEQ);
    assign complete = active_r && (wait_cnt == '0);

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_r <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (hready)
                active_r <= accept;
            if (accept)
                wait_cnt <= CNT_WIDTH'(WAIT_STATES);
            else if (wait_cnt != '0)
                wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // Address phase capture
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_r   <= req.haddr[RAM_ADDR_WIDTH+1:2];
            size_r   <= req.hsize;
            offset_r <= req.haddr[1:0];
            write_r  <= req.hwrite;
        end
    end

    // Little-endian byte lanes
    always_comb begin
        lane_en = '0;
        case (size_r)
            HSIZE_BYTE: lane_en[offset_r] = 1'b1;
            HSIZE_HALF: lane_en = offset_r[1] ? 4'b1100 : 4'b0011;
            default:    lane_en = 4'b1111;
        endcase
    end

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (complete && write_r) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i])
                    mem[addr_r].lane[i] <= hwdata.lane[i];
            end
        end
    end

    always_comb begin
        rsp.hrdata    = mem[addr_r];
        rsp.hreadyout = (wait_cnt == '0);  // Low while counting
        rsp.hresp     = 1'b0;
    end

endmodule

//--- design/ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [31:0]       haddr,
    input  logic              hready,
    output ahb_pkg::dev_sel_t hsel,
    output ahb_pkg::dev_sel_t hsel_r
);
    import ahb_pkg::*;

    // --------------------
    // Address phase decode
    // --------------------
    always_comb begin
        hsel = '0;

        // RAM, 64 MB window at physical 0x00000000
        hsel[DEV_RAM] = (haddr[28:26] == RAM_ADDR_MATCH);

        // GPIO, 4 MB window at physical 0x1f800000
        hsel[DEV_GPIO] = (haddr[28:22] == GPIO_ADDR_MATCH);
    end

    // --------------------
    // Data phase owner
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsel_r <= '0;
        end else if (hready) begin
            hsel_r <= hsel;  // Held across wait states
        end
    end

endmodule

//--- design/ahb_pkg.sv
package ahb_pkg;

    // --------------------
    // Address map
    // --------------------
    localparam int DEVICE_COUNT = 2;
    localparam int DEV_RAM      = 0;
    localparam int DEV_GPIO     = 1;

    localparam logic [2:0] RAM_ADDR_MATCH  = 3'h0;   // 0x00000000, addr[28:26]
    localparam logic [6:0] GPIO_ADDR_MATCH = 7'h7e;  // 0x1f800000, addr[28:22]

    localparam int RAM_ADDR_WIDTH  = 10;  // Word address, 4 KB
    localparam int RAM_WAIT_STATES = 1;

    // --------------------
    // GPIO
    // --------------------
    localparam int N_RED_LEDS        = 18;
    localparam int N_GREEN_LEDS      = 8;
    localparam int N_SWITCHES        = 18;
    localparam int N_BUTTONS         = 5;
    localparam int HEX_WIDTH         = 32;
    localparam int GPIO_OFFSET_WIDTH = 5;

    localparam logic [GPIO_OFFSET_WIDTH-1:0] GPIO_RED_OFFSET   = 5'h00;
    localparam logic [GPIO_OFFSET_WIDTH-1:0] GPIO_GREEN_OFFSET = 5'h04;
    localparam logic [GPIO_OFFSET_WIDTH-1:0] GPIO_HEX_OFFSET   = 5'h08;
    localparam logic [GPIO_OFFSET_WIDTH-1:0] GPIO_SW_OFFSET    = 5'h0c;
    localparam logic [GPIO_OFFSET_WIDTH-1:0] GPIO_BTN_OFFSET   = 5'h10;

    // --------------------
    // Bus encodings
    // --------------------
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    localparam logic [2:0] HSIZE_BYTE = 3'b000;
    localparam logic [2:0] HSIZE_HALF = 3'b001;
    localparam logic [2:0] HSIZE_WORD = 3'b010;

    // One bus word, whole or by byte lane (lane 0 is the lowest address)
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } ahb_data_u;

    typedef struct packed {
        logic [31:0] haddr;
        logic [2:0]  hsize;
        logic [1:0]  htrans;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed {
        ahb_data_u hrdata;
        logic      hreadyout;
        logic      hresp;
    } ahb_rsp_t;

    typedef logic [DEVICE_COUNT-1:0] dev_sel_t;

    typedef struct packed {
        logic [N_SWITCHES-1:0] switches;
        logic [N_BUTTONS-1:0]  buttons;
    } gpio_in_t;

    typedef struct packed {
        logic [N_RED_LEDS-1:0]   red_leds;
        logic [N_GREEN_LEDS-1:0] green_leds;
        logic [HEX_WIDTH-1:0]    hex;
    } gpio_out_t;

endpackage
